/* hw/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  ////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////
  localparam int riscv_regaddr_w = 5;
  localparam int riscv_xlen      = 32;
  localparam int riscv_md_iters  = 32;   // one quotient/product bit per iteration

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // base opcodes seen by the pipeline control
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_op     = 7'b0110011,
    op_opimm  = 7'b0010011,
    op_branch = 7'b1100011,
    op_system = 7'b1110011
  } riscv_opcode_e;

  typedef enum logic [1:0] {
    res_alu     = 2'b00,
    res_pcplus4 = 2'b01,
    res_mem     = 2'b10,   // load in flight
    res_csr     = 2'b11
  } riscv_resultsrc_e;

  // operand mux selects in execute
  typedef enum logic [1:0] {
    fwd_rf  = 2'b00,
    fwd_wb  = 2'b01,
    fwd_mem = 2'b10,
    fwd_lui = 2'b11   // immediate of a lui sitting in memory
  } riscv_fwd_e;

  typedef enum logic [1:0] {
    md_idle = 2'b00,
    md_busy = 2'b01,
    md_done = 2'b10
  } riscv_mdstate_e;

endpackage

`default_nettype wire

/* hw/riscv_hazardunit.sv */
`default_nettype none

module riscv_hazardunit (
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rs1addr_d,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rs2addr_d,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rs1addr_e,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rs2addr_e,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rdaddr_e,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rdaddr_m,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_hzrdu_rdaddr_w,
  input  riscv_pkg::riscv_opcode_e               i_riscv_hzrdu_opcode_m,
  input  logic                                   i_riscv_hzrdu_pcsrc,
  input  logic                                   i_riscv_hzrdu_regw_m,
  input  logic                                   i_riscv_hzrdu_regw_w,
  input  riscv_pkg::riscv_resultsrc_e            i_riscv_hzrdu_resultsrc_e,
  input  logic                                   i_riscv_dcache_stall_m,
  input  logic                                   i_riscv_hzrdu_mul_en,
  input  logic                                   i_riscv_hzrdu_div_en,
  input  logic                                   i_riscv_hzrdu_valid,
  input  logic                                   i_riscv_hzrdu_iscsr_e,
  input  logic                                   i_riscv_hzrdu_iscsr_d,
  output riscv_pkg::riscv_fwd_e                  o_riscv_hzrdu_fwda,
  output riscv_pkg::riscv_fwd_e                  o_riscv_hzrdu_fwdb,
  output logic                                   o_riscv_hzrdu_stallpc,
  output logic                                   o_riscv_hzrdu_stallfd,
  output logic                                   o_riscv_hzrdu_flushfd,
  output logic                                   o_riscv_hzrdu_flushde,
  output logic                                   o_riscv_hzrdu_stallde,
  output logic                                   o_riscv_hzrdu_stallem,
  output logic                                   o_riscv_hzrdu_stallmw
);
  import riscv_pkg::*;

  logic m_stall;
  logic glob_stall;
  logic src_hit_e;
  logic ld_hzrd;

  // priority: lui in M, any write in M, then write in W
  function automatic riscv_fwd_e fwd_sel(input logic [riscv_regaddr_w-1:0] src);
    logic hit_m;
    logic hit_w;
    hit_m = (src == i_riscv_hzrdu_rdaddr_m) && i_riscv_hzrdu_regw_m &&
            (i_riscv_hzrdu_rdaddr_m != '0);
    hit_w = (src == i_riscv_hzrdu_rdaddr_w) && i_riscv_hzrdu_regw_w &&
            (i_riscv_hzrdu_rdaddr_w != '0);
    if (hit_m && (i_riscv_hzrdu_opcode_m == op_lui))
      return fwd_lui;
    else if (hit_m)
      return fwd_mem;
    else if (hit_w)
      return fwd_wb;
    else
      return fwd_rf;
  endfunction

  ////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////
  always_comb
  begin
    o_riscv_hzrdu_fwda = fwd_sel(i_riscv_hzrdu_rs1addr_e);
    o_riscv_hzrdu_fwdb = fwd_sel(i_riscv_hzrdu_rs2addr_e);
  end

  ////////////////////////////////////////
  // stalls and flushes
  ////////////////////////////////////////
  assign src_hit_e = (i_riscv_hzrdu_rs1addr_d == i_riscv_hzrdu_rdaddr_e) ||
                     (i_riscv_hzrdu_rs2addr_d == i_riscv_hzrdu_rdaddr_e);

  // csr result is only known late, so treat it like a load unless decode is csr too
  assign ld_hzrd = src_hit_e &&
                   ((i_riscv_hzrdu_resultsrc_e == res_mem) ||
                    (i_riscv_hzrdu_iscsr_e && !i_riscv_hzrdu_iscsr_d));

  assign m_stall    = (i_riscv_hzrdu_mul_en || i_riscv_hzrdu_div_en) && !i_riscv_hzrdu_valid;
  assign glob_stall = i_riscv_dcache_stall_m || m_stall;

  assign o_riscv_hzrdu_stallpc = ld_hzrd || glob_stall;
  assign o_riscv_hzrdu_stallfd = ld_hzrd || glob_stall;
  assign o_riscv_hzrdu_flushde = ld_hzrd || i_riscv_hzrdu_pcsrc;   // bubble into E
  assign o_riscv_hzrdu_flushfd = i_riscv_hzrdu_pcsrc;

  assign o_riscv_hzrdu_stallde = glob_stall;
  assign o_riscv_hzrdu_stallem = glob_stall;
  assign o_riscv_hzrdu_stallmw = glob_stall;

  // a taken branch must also kill whatever sits in decode
  a_flush_pair : assert final (!o_riscv_hzrdu_flushfd || o_riscv_hzrdu_flushde);

  // x0 in writeback is never a forward source
  a_no_wb_x0 : assert final (!((o_riscv_hzrdu_fwda == fwd_wb) &&
                               (i_riscv_hzrdu_rdaddr_w == '0)));

endmodule

`default_nettype wire

/* hw/riscv_stage_track.sv */
`default_nettype none

module riscv_stage_track (
  input  logic                                   i_riscv_clk,
  input  logic                                   i_rst_n,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_rs1addr_d,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_rs2addr_d,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_rdaddr_d,
  input  logic                                   i_riscv_regw_d,
  input  riscv_pkg::riscv_opcode_e               i_riscv_opcode_d,
  input  riscv_pkg::riscv_resultsrc_e            i_riscv_resultsrc_d,
  input  logic                                   i_riscv_iscsr_d,
  input  logic                                   i_riscv_mul_en_d,
  input  logic                                   i_riscv_div_en_d,
  input  logic                                   i_riscv_stallde,
  input  logic                                   i_riscv_flushde,
  input  logic                                   i_riscv_stallem,
  input  logic                                   i_riscv_stallmw,
  output logic [riscv_pkg::riscv_regaddr_w-1:0] o_riscv_rs1addr_e,
  output logic [riscv_pkg::riscv_regaddr_w-1:0] o_riscv_rs2addr_e,
  output logic [riscv_pkg::riscv_regaddr_w-1:0] o_riscv_rdaddr_e,
  output riscv_pkg::riscv_resultsrc_e            o_riscv_resultsrc_e,
  output logic                                   o_riscv_iscsr_e,
  output logic                                   o_riscv_mul_en_e,
  output logic                                   o_riscv_div_en_e,
  output logic [riscv_pkg::riscv_regaddr_w-1:0] o_riscv_rdaddr_m,
  output logic                                   o_riscv_regw_m,
  output riscv_pkg::riscv_opcode_e               o_riscv_opcode_m,
  output logic [riscv_pkg::riscv_regaddr_w-1:0] o_riscv_rdaddr_w,
  output logic                                   o_riscv_regw_w,
  output logic                                   o_riscv_iscsr_w
);
  import riscv_pkg::*;

  logic          regw_e;
  riscv_opcode_e opcode_e;
  logic          iscsr_m;

  ////////////////////////////////////////
  // decode -> execute
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_riscv_rs1addr_e   <= '0;
      o_riscv_rs2addr_e   <= '0;
      o_riscv_rdaddr_e    <= '0;
      regw_e              <= 1'b0;
      opcode_e            <= op_opimm;
      o_riscv_resultsrc_e <= res_alu;
      o_riscv_iscsr_e     <= 1'b0;
      o_riscv_mul_en_e    <= 1'b0;
      o_riscv_div_en_e    <= 1'b0;
    end
    else if (!i_riscv_stallde)
    begin
      if (i_riscv_flushde)   // bubble, behaves as addi x0
      begin
        o_riscv_rs1addr_e   <= '0;
        o_riscv_rs2addr_e   <= '0;
        o_riscv_rdaddr_e    <= '0;
        regw_e              <= 1'b0;
        opcode_e            <= op_opimm;
        o_riscv_resultsrc_e <= res_alu;
        o_riscv_iscsr_e     <= 1'b0;
        o_riscv_mul_en_e    <= 1'b0;
        o_riscv_div_en_e    <= 1'b0;
      end
      else
      begin
        o_riscv_rs1addr_e   <= i_riscv_rs1addr_d;
        o_riscv_rs2addr_e   <= i_riscv_rs2addr_d;
        o_riscv_rdaddr_e    <= i_riscv_rdaddr_d;
        regw_e              <= i_riscv_regw_d;
        opcode_e            <= i_riscv_opcode_d;
        o_riscv_resultsrc_e <= i_riscv_resultsrc_d;
        o_riscv_iscsr_e     <= i_riscv_iscsr_d;
        o_riscv_mul_en_e    <= i_riscv_mul_en_d;
        o_riscv_div_en_e    <= i_riscv_div_en_d;
      end
    end
  end

  ////////////////////////////////////////
  // execute -> memory -> writeback
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_riscv_rdaddr_m <= '0;
      o_riscv_regw_m   <= 1'b0;
      o_riscv_opcode_m <= op_opimm;
      iscsr_m          <= 1'b0;
    end
    else if (!i_riscv_stallem)
    begin
      o_riscv_rdaddr_m <= o_riscv_rdaddr_e;
      o_riscv_regw_m   <= regw_e;
      o_riscv_opcode_m <= opcode_e;
      iscsr_m          <= o_riscv_iscsr_e;
    end
  end

  always_ff @(posedge i_riscv_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_riscv_rdaddr_w <= '0;
      o_riscv_regw_w   <= 1'b0;
      o_riscv_iscsr_w  <= 1'b0;
    end
    else if (!i_riscv_stallmw)
    begin
      o_riscv_rdaddr_w <= o_riscv_rdaddr_m;
      o_riscv_regw_w   <= o_riscv_regw_m;
      o_riscv_iscsr_w  <= iscsr_m;
    end
  end

  a_m_hold : assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    i_riscv_stallem |=> $stable({o_riscv_rdaddr_m, o_riscv_regw_m, o_riscv_opcode_m, iscsr_m}));

endmodule

`default_nettype wire

/* hw/riscv_muldiv_seq.sv */
`default_nettype none

module riscv_muldiv_seq (
  input  logic                             i_riscv_clk,
  input  logic                             i_rst_n,
  input  logic                             i_riscv_md_mul_en,
  input  logic                             i_riscv_md_div_en,
  input  logic [riscv_pkg::riscv_xlen-1:0] i_riscv_md_srca,
  input  logic [riscv_pkg::riscv_xlen-1:0] i_riscv_md_srcb,
  input  logic                             i_riscv_md_dcache_stall,
  output logic                             o_riscv_md_valid,
  output logic [riscv_pkg::riscv_xlen-1:0] o_riscv_md_result
);
  import riscv_pkg::*;

  riscv_mdstate_e                    md_state;
  logic [$clog2(riscv_md_iters)-1:0] iter_cnt;
  logic                              is_div;
  logic [riscv_xlen-1:0]             opa_q;    // multiplier, or dividend turning into quotient
  logic [riscv_xlen-1:0]             opb_q;    // multiplicand or divisor
  logic [riscv_xlen:0]               acc_q;    // product or partial remainder
  logic [riscv_xlen:0]               rem_sh;
  logic [riscv_xlen:0]               rem_sub;
  logic                              div_ge;

  // restoring step, a zero divisor always fits so the quotient fills with ones
  assign rem_sh  = {acc_q[riscv_xlen-1:0], opa_q[riscv_xlen-1]};
  assign div_ge  = (rem_sh >= {1'b0, opb_q});
  assign rem_sub = rem_sh - {1'b0, opb_q};

  ////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      md_state <= md_idle;
      iter_cnt <= '0;
      is_div   <= 1'b0;
    end
    else
    begin
      case (md_state)
        md_idle:
          if (i_riscv_md_mul_en || i_riscv_md_div_en)
          begin
            md_state <= md_busy;
            iter_cnt <= '0;
            is_div   <= i_riscv_md_div_en;
          end
        md_busy:
        begin
          iter_cnt <= iter_cnt + 1'b1;
          if (int'(iter_cnt) == riscv_md_iters - 1)
            md_state <= md_done;
        end
        default:   // md_done, held while the cache freezes the pipe
          if (!i_riscv_md_dcache_stall)
            md_state <= md_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk)
  begin
    if (md_state == md_idle)
    begin
      opa_q <= i_riscv_md_srca;
      opb_q <= i_riscv_md_srcb;
      acc_q <= '0;
    end
    else if (md_state == md_busy)
    begin
      if (is_div)
      begin
        opa_q <= {opa_q[riscv_xlen-2:0], div_ge};
        acc_q <= div_ge ? rem_sub : rem_sh;
      end
      else
      begin
        acc_q <= acc_q + (opa_q[0] ? {1'b0, opb_q} : '0);
        opa_q <= opa_q >> 1;
        opb_q <= opb_q << 1;
      end
    end
  end

  assign o_riscv_md_valid  = (md_state == md_done);
  assign o_riscv_md_result = is_div ? opa_q : acc_q[riscv_xlen-1:0];

  a_valid_pulse : assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    (o_riscv_md_valid && !i_riscv_md_dcache_stall) |=> !o_riscv_md_valid);

endmodule

`default_nettype wire

/* hw/riscv_pipe_ctrl.sv */
`default_nettype none

module riscv_pipe_ctrl (
  input  logic                                   i_riscv_clk,
  input  logic                                   i_rst_n,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_rs1addr_d,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_rs2addr_d,
  input  logic [riscv_pkg::riscv_regaddr_w-1:0] i_riscv_rdaddr_d,
  input  logic                                   i_riscv_regw_d,
  input  riscv_pkg::riscv_opcode_e               i_riscv_opcode_d,
  input  riscv_pkg::riscv_resultsrc_e            i_riscv_resultsrc_d,
  input  logic                                   i_riscv_iscsr_d,
  input  logic                                   i_riscv_mul_en_d,
  input  logic                                   i_riscv_div_en_d,
  input  logic                                   i_riscv_pcsrc,
  input  logic                                   i_riscv_dcache_stall_m,
  input  logic [riscv_pkg::riscv_xlen-1:0]       i_riscv_srca_e,
  input  logic [riscv_pkg::riscv_xlen-1:0]       i_riscv_srcb_e,
  output riscv_pkg::riscv_fwd_e                  o_riscv_fwda,
  output riscv_pkg::riscv_fwd_e                  o_riscv_fwdb,
  output logic                                   o_riscv_stallpc,
  output logic                                   o_riscv_stallfd,
  output logic                                   o_riscv_flushfd,
  output logic                                   o_riscv_flushde,
  output logic                                   o_riscv_stallde,
  output logic                                   o_riscv_stallem,
  output logic                                   o_riscv_stallmw,
  output logic                                   o_riscv_md_valid,
  output logic [riscv_pkg::riscv_xlen-1:0]       o_riscv_md_result
);
  import riscv_pkg::*;

  logic [riscv_regaddr_w-1:0] rs1addr_e;
  logic [riscv_regaddr_w-1:0] rs2addr_e;
  logic [riscv_regaddr_w-1:0] rdaddr_e;
  riscv_resultsrc_e           resultsrc_e;
  logic                       iscsr_e;
  logic                       mul_en_e;
  logic                       div_en_e;
  logic [riscv_regaddr_w-1:0] rdaddr_m;
  logic                       regw_m;
  riscv_opcode_e              opcode_m;
  logic [riscv_regaddr_w-1:0] rdaddr_w;
  logic                       regw_w;

  riscv_stage_track u_stage_track (
    .i_riscv_clk         (i_riscv_clk),
    .i_rst_n             (i_rst_n),
    .i_riscv_rs1addr_d   (i_riscv_rs1addr_d),
    .i_riscv_rs2addr_d   (i_riscv_rs2addr_d),
    .i_riscv_rdaddr_d    (i_riscv_rdaddr_d),
    .i_riscv_regw_d      (i_riscv_regw_d),
    .i_riscv_opcode_d    (i_riscv_opcode_d),
    .i_riscv_resultsrc_d (i_riscv_resultsrc_d),
    .i_riscv_iscsr_d     (i_riscv_iscsr_d),
    .i_riscv_mul_en_d    (i_riscv_mul_en_d),
    .i_riscv_div_en_d    (i_riscv_div_en_d),
    .i_riscv_stallde     (o_riscv_stallde),
    .i_riscv_flushde     (o_riscv_flushde),
    .i_riscv_stallem     (o_riscv_stallem),
    .i_riscv_stallmw     (o_riscv_stallmw),
    .o_riscv_rs1addr_e   (rs1addr_e),
    .o_riscv_rs2addr_e   (rs2addr_e),
    .o_riscv_rdaddr_e    (rdaddr_e),
    .o_riscv_resultsrc_e (resultsrc_e),
    .o_riscv_iscsr_e     (iscsr_e),
    .o_riscv_mul_en_e    (mul_en_e),
    .o_riscv_div_en_e    (div_en_e),
    .o_riscv_rdaddr_m    (rdaddr_m),
    .o_riscv_regw_m      (regw_m),
    .o_riscv_opcode_m    (opcode_m),
    .o_riscv_rdaddr_w    (rdaddr_w),
    .o_riscv_regw_w      (regw_w),
    .o_riscv_iscsr_w     ()   // writeback csr flag has no consumer here
  );

  riscv_hazardunit u_hazardunit (
    .i_riscv_hzrdu_rs1addr_d   (i_riscv_rs1addr_d),
    .i_riscv_hzrdu_rs2addr_d   (i_riscv_rs2addr_d),
    .i_riscv_hzrdu_rs1addr_e   (rs1addr_e),
    .i_riscv_hzrdu_rs2addr_e   (rs2addr_e),
    .i_riscv_hzrdu_rdaddr_e    (rdaddr_e),
    .i_riscv_hzrdu_rdaddr_m    (rdaddr_m),
    .i_riscv_hzrdu_rdaddr_w    (rdaddr_w),
    .i_riscv_hzrdu_opcode_m    (opcode_m),
    .i_riscv_hzrdu_pcsrc       (i_riscv_pcsrc),
    .i_riscv_hzrdu_regw_m      (regw_m),
    .i_riscv_hzrdu_regw_w      (regw_w),
    .i_riscv_hzrdu_resultsrc_e (resultsrc_e),
    .i_riscv_dcache_stall_m    (i_riscv_dcache_stall_m),
    .i_riscv_hzrdu_mul_en      (mul_en_e),
    .i_riscv_hzrdu_div_en      (div_en_e),
    .i_riscv_hzrdu_valid       (o_riscv_md_valid),
    .i_riscv_hzrdu_iscsr_e     (iscsr_e),
    .i_riscv_hzrdu_iscsr_d     (i_riscv_iscsr_d),
    .o_riscv_hzrdu_fwda        (o_riscv_fwda),
    .o_riscv_hzrdu_fwdb        (o_riscv_fwdb),
    .o_riscv_hzrdu_stallpc     (o_riscv_stallpc),
    .o_riscv_hzrdu_stallfd     (o_riscv_stallfd),
    .o_riscv_hzrdu_flushfd     (o_riscv_flushfd),
    .o_riscv_hzrdu_flushde     (o_riscv_flushde),
    .o_riscv_hzrdu_stallde     (o_riscv_stallde),
    .o_riscv_hzrdu_stallem     (o_riscv_stallem),
    .o_riscv_hzrdu_stallmw     (o_riscv_stallmw)
  );

  riscv_muldiv_seq u_muldiv_seq (
    .i_riscv_clk             (i_riscv_clk),
    .i_rst_n                 (i_rst_n),
    .i_riscv_md_mul_en       (mul_en_e),
    .i_riscv_md_div_en       (div_en_e),
    .i_riscv_md_srca         (i_riscv_srca_e),
    .i_riscv_md_srcb         (i_riscv_srcb_e),
    .i_riscv_md_dcache_stall (i_riscv_dcache_stall_m),
    .o_riscv_md_valid        (o_riscv_md_valid),
    .o_riscv_md_result       (o_riscv_md_result)
  );

endmodule

`default_nettype wire

/* verification/riscv_clkgen.sv */
`default_nettype none

module riscv_clkgen (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 4;   // ns, 8 ns period

  initial
  begin
    o_clk = 1'b0;
    forever
      #half_period o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

/* verification/riscv_pipe_ctrl_tb.sv */
`default_nettype none

module riscv_pipe_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import riscv_pkg::*;

  localparam int clk_period = 8;
  localparam int n_fwd      = 200;
  localparam int n_ldcsr    = 200;
  localparam int n_branch   = 200;
  localparam int n_muldiv   = 400;
  localparam int n_dcache   = 300;
  localparam int n_mix      = 1500;
  localparam int total_cycles = n_fwd + n_ldcsr + n_branch + n_muldiv + n_dcache + n_mix;

  logic                       clk;
  logic                       rst_n;
  logic [riscv_regaddr_w-1:0] rs1addr_d;
  logic [riscv_regaddr_w-1:0] rs2addr_d;
  logic [riscv_regaddr_w-1:0] rdaddr_d;
  logic                       regw_d;
  riscv_opcode_e              opcode_d;
  riscv_resultsrc_e           resultsrc_d;
  logic                       iscsr_d;
  logic                       mul_en_d;
  logic                       div_en_d;
  logic                       pcsrc;
  logic                       dcache_stall;
  logic [riscv_xlen-1:0]      srca_e;
  logic [riscv_xlen-1:0]      srcb_e;
  riscv_fwd_e                 fwda;
  riscv_fwd_e                 fwdb;
  logic                       stallpc, stallfd, flushfd, flushde;
  logic                       stallde, stallem, stallmw;
  logic                       md_valid;
  logic [riscv_xlen-1:0]      md_result;

  integer seed = 14825;
  int     k_lui, k_load, k_csr, k_br, k_md, k_dc;   // percent knobs of the running test
  int     n_valid_seen;
  int     n_lui_seen;

  // model of the E, M and W descriptors and the mul/div sequencer
  logic [riscv_regaddr_w-1:0] e_rs1, e_rs2, e_rd, m_rd, w_rd;
  logic                       e_regw, e_csr, e_mul, e_div, m_regw, w_regw;
  riscv_resultsrc_e           e_res;
  riscv_opcode_e              e_op, m_op;
  logic                       md_busy_q, md_done_q;
  int                         md_left;
  logic [riscv_xlen-1:0]      md_exp;
  riscv_fwd_e                 x_fwda, x_fwdb;
  logic                       x_hzrd, x_glob, x_valid, x_flushde;

  riscv_clkgen u_clkgen (.o_clk(clk));

  riscv_pipe_ctrl i_riscv_pipe_ctrl (
    .i_riscv_clk         (clk),
    .i_rst_n             (rst_n),
    .i_riscv_rs1addr_d   (rs1addr_d),
    .i_riscv_rs2addr_d   (rs2addr_d),
    .i_riscv_rdaddr_d    (rdaddr_d),
    .i_riscv_regw_d      (regw_d),
    .i_riscv_opcode_d    (opcode_d),
    .i_riscv_resultsrc_d (resultsrc_d),
    .i_riscv_iscsr_d     (iscsr_d),
    .i_riscv_mul_en_d    (mul_en_d),
    .i_riscv_div_en_d    (div_en_d),
    .i_riscv_pcsrc       (pcsrc),
    .i_riscv_dcache_stall_m (dcache_stall),
    .i_riscv_srca_e      (srca_e),
    .i_riscv_srcb_e      (srcb_e),
    .o_riscv_fwda        (fwda),
    .o_riscv_fwdb        (fwdb),
    .o_riscv_stallpc     (stallpc),
    .o_riscv_stallfd     (stallfd),
    .o_riscv_flushfd     (flushfd),
    .o_riscv_flushde     (flushde),
    .o_riscv_stallde     (stallde),
    .o_riscv_stallem     (stallem),
    .o_riscv_stallmw     (stallmw),
    .o_riscv_md_valid    (md_valid),
    .o_riscv_md_result   (md_result)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic logic [riscv_regaddr_w-1:0] rand_addr();
    logic [31:0] r;
    r = $unsigned($random(seed));
    if (chance(80))
      return r % 4;   // narrow range so sources and destinations collide
    return r % 32;
  endfunction

  function automatic riscv_fwd_e expect_fwd(input logic [riscv_regaddr_w-1:0] src);
    logic in_m;
    logic in_w;
    in_m = m_regw && (m_rd != 0) && (src == m_rd);
    in_w = w_regw && (w_rd != 0) && (src == w_rd);
    if (in_m)
      return (m_op == op_lui) ? fwd_lui : fwd_mem;
    if (in_w)
      return fwd_wb;
    return fwd_rf;
  endfunction

  task automatic check_value(input string test, input string sig,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("mismatch %s %s expected 0x%0h actual 0x%0h", test, sig, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic drive_random();
    rs1addr_d   = rand_addr();
    rs2addr_d   = rand_addr();
    rdaddr_d    = rand_addr();
    regw_d      = chance(85);
    iscsr_d     = 1'b0;
    mul_en_d    = 1'b0;
    div_en_d    = 1'b0;
    resultsrc_d = res_alu;
    case ($unsigned($random(seed)) % 4)
      0:       opcode_d = op_op;
      1:       opcode_d = op_opimm;
      2:       opcode_d = op_store;
      default: opcode_d = op_branch;
    endcase
    if (chance(k_lui))
      opcode_d = op_lui;
    else if (chance(k_load))
    begin
      opcode_d    = op_load;
      resultsrc_d = res_mem;
    end
    else if (chance(k_csr))
    begin
      opcode_d    = op_system;
      resultsrc_d = res_csr;
      iscsr_d     = 1'b1;
    end
    else if (chance(k_md))
    begin
      opcode_d = op_op;
      if (chance(50))
        mul_en_d = 1'b1;
      else
        div_en_d = 1'b1;
    end
    pcsrc        = chance(k_br);
    dcache_stall = chance(k_dc);
    srca_e       = $random(seed);
    srcb_e       = chance(20) ? '0 : $random(seed);   // exercise divide by zero
  endtask

  task automatic reset_model();
    {e_rs1, e_rs2, e_rd, m_rd, w_rd} = '0;
    {e_regw, e_csr, e_mul, e_div, m_regw, w_regw} = '0;
    e_res     = res_alu;
    e_op      = op_opimm;
    m_op      = op_opimm;
    md_busy_q = 1'b0;
    md_done_q = 1'b0;
    md_left   = 0;
    md_exp    = '0;
  endtask

  ////////////////////////////////////////
  // one cycle, entered and left at a falling edge
  ////////////////////////////////////////
  task automatic step(input string test);
    drive_random();
    #1;
    x_fwda    = expect_fwd(e_rs1);
    x_fwdb    = expect_fwd(e_rs2);
    x_valid   = md_done_q;
    x_hzrd    = ((rs1addr_d == e_rd) || (rs2addr_d == e_rd)) &&
                ((e_res == res_mem) || (e_csr && !iscsr_d));
    x_glob    = dcache_stall || ((e_mul || e_div) && !x_valid);
    x_flushde = x_hzrd || pcsrc;
    check_value(test, "fwda", x_fwda, fwda);
    check_value(test, "fwdb", x_fwdb, fwdb);
    check_value(test, "stallpc", x_hzrd || x_glob, stallpc);
    check_value(test, "stallfd", x_hzrd || x_glob, stallfd);
    check_value(test, "flushfd", pcsrc, flushfd);
    check_value(test, "flushde", x_flushde, flushde);
    check_value(test, "stallde", x_glob, stallde);
    check_value(test, "stallem", x_glob, stallem);
    check_value(test, "stallmw", x_glob, stallmw);
    check_value(test, "md_valid", x_valid, md_valid);
    if (x_valid)
    begin
      check_value(test, "md_result", md_exp, md_result);
      n_valid_seen++;
    end
    if ((x_fwda == fwd_lui) || (x_fwdb == fwd_lui))
      n_lui_seen++;

    @(posedge clk);
    // mul/div first, it looks at E before E moves
    if (md_done_q)
    begin
      if (!dcache_stall)
        md_done_q = 1'b0;
    end
    else if (md_busy_q)
    begin
      md_left--;
      if (md_left == 0)
      begin
        md_busy_q = 1'b0;
        md_done_q = 1'b1;
      end
    end
    else if (e_mul || e_div)
    begin
      md_busy_q = 1'b1;
      md_left   = riscv_md_iters;
      if (e_div)
        md_exp = (srcb_e == 0) ? '1 : srca_e / srcb_e;
      else
        md_exp = srca_e * srcb_e;   // low word only
    end

    if (!x_glob)
    begin
      w_rd   = m_rd;
      w_regw = m_regw;
      m_rd   = e_rd;
      m_regw = e_regw;
      m_op   = e_op;
      if (x_flushde)
      begin
        {e_rs1, e_rs2, e_rd} = '0;
        {e_regw, e_csr, e_mul, e_div} = '0;
        e_res = res_alu;
        e_op  = op_opimm;
      end
      else
      begin
        e_rs1  = rs1addr_d;
        e_rs2  = rs2addr_d;
        e_rd   = rdaddr_d;
        e_regw = regw_d;
        e_op   = opcode_d;
        e_res  = resultsrc_d;
        e_csr  = iscsr_d;
        e_mul  = mul_en_d;
        e_div  = div_en_d;
      end
    end
    @(negedge clk);
  endtask

  task automatic run_test(input string test, input int cycles, input int p_lui, input int p_load,
                          input int p_csr, input int p_br, input int p_md, input int p_dc);
    k_lui  = p_lui;
    k_load = p_load;
    k_csr  = p_csr;
    k_br   = p_br;
    k_md   = p_md;
    k_dc   = p_dc;
    repeat (cycles)
      step(test);
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////
  initial
  begin
    rst_n        = 1'b0;
    rs1addr_d    = '0;
    rs2addr_d    = '0;
    rdaddr_d     = '0;
    regw_d       = 1'b0;
    opcode_d     = op_opimm;
    resultsrc_d  = res_alu;
    iscsr_d      = 1'b0;
    mul_en_d     = 1'b0;
    div_en_d     = 1'b0;
    pcsrc        = 1'b0;
    dcache_stall = 1'b0;
    srca_e       = '0;
    srcb_e       = '0;
    n_valid_seen = 0;
    n_lui_seen   = 0;
    reset_model();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    run_test("forwarding",     n_fwd,    40, 0,  0,  0,  0,  0);
    run_test("load_csr_stall", n_ldcsr,  10, 30, 20, 0,  0,  0);
    run_test("branch_flush",   n_branch, 10, 10, 5,  25, 0,  0);
    run_test("muldiv",         n_muldiv, 10, 0,  0,  0,  15, 0);
    run_test("dcache_stall",   n_dcache, 20, 10, 5,  10, 5,  35);
    run_test("random_mix",     n_mix,    15, 15, 10, 10, 4,  15);

    if ((n_valid_seen == 0) || (n_lui_seen == 0))
    begin
      $display("no mul/div result or no lui forward was observed during the run");
      $display("=== FAIL ===");
      $fatal(1, "stimulus missed a behavior");
    end
    else
    begin
      $display("=== PASS ===");
      $finish;
    end
  end

  // watchdog, all tests plus reset and some slack
  initial
  begin
    #((total_cycles + 100) * clk_period);
    $display("timeout: simulation hung after %0d ns", (total_cycles + 100) * clk_period);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/riscv_pkg.sv
hw/riscv_hazardunit.sv
hw/riscv_stage_track.sv
hw/riscv_muldiv_seq.sv
hw/riscv_pipe_ctrl.sv
verification/riscv_clkgen.sv
verification/riscv_pipe_ctrl_tb.sv

/* Bender.yml */
package:
  name: riscv_pipe_ctrl

sources:
  - files:
      - hw/riscv_pkg.sv
      - hw/riscv_hazardunit.sv
      - hw/riscv_stage_track.sv
      - hw/riscv_muldiv_seq.sv
      - hw/riscv_pipe_ctrl.sv
  - target: test
    files:
      - verification/riscv_clkgen.sv
      - verification/riscv_pipe_ctrl_tb.sv
